// File: mips.f
+incdir+include
hdl/mipsPkg.sv
hdl/mipsIfs.sv
hdl/fetchStage.sv
hdl/registerFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/mips.sv
test/mipsTb.sv

// File: Bender.yml
package:
  name: mips

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/mipsPkg.sv
      - hdl/mipsIfs.sv
      - hdl/fetchStage.sv
      - hdl/registerFile.sv
      - hdl/decodeStage.sv
      - hdl/executeStage.sv
      - hdl/memoryStage.sv
      - hdl/mips.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/mipsTb.sv

// File: test/mipsTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module mipsTb;
    import mipsPkg::*;

    localparam int clkPeriod    = 100;
    localparam int inputDelay   = 10;  // Drive point after the rising edge
    localparam int programWords = 44;  // Sum of all test program lengths

    logic       clk;
    logic       reset;
    wordT       instRdata;
    wordT       instAddr;
    wordT       dataRdata;
    wordT       dataAddr;
    wordT       dataWdata;
    logic [3:0] dataByteen;
    wordT       memInstAddr;
    logic       grfWe;
    regAddrT    grfAddr;
    wordT       grfWdata;
    wordT       wbInstAddr;
    wordT       imemOffset;

    wordT imem [0:63];
    wordT dmem [0:255];
    wordT modelRegs [0:31];
    wordT modelMem [0:255];
    int   progLen;
    int   errorCount;
    int   checkCount;

    // Seen on the DUT trace ports
    regAddrT    recAddr [$];
    wordT       recValue [$];
    wordT       recPc [$];
    wordT       recStAddr [$];
    wordT       recStData [$];
    logic [3:0] recStEn [$];
    wordT       recStPc [$];
    // From the architectural model
    regAddrT    expAddr [$];
    wordT       expValue [$];
    wordT       expPc [$];
    wordT       expStAddr [$];
    wordT       expStData [$];
    wordT       expStPc [$];

    mips mips_i (
        .clk        (clk),
        .reset      (reset),
        .instRdata  (instRdata),
        .instAddr   (instAddr),
        .dataRdata  (dataRdata),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataByteen (dataByteen),
        .memInstAddr(memInstAddr),
        .grfWe      (grfWe),
        .grfAddr    (grfAddr),
        .grfWdata   (grfWdata),
        .wbInstAddr (wbInstAddr)
    );

    // Both memories answer combinationally
    assign imemOffset = instAddr - `MIPS_RESET_PC;
    assign instRdata  = (imemOffset < 32'd256) ? imem[imemOffset[7:2]] : 32'h0;  // nop outside
    assign dataRdata  = dmem[dataAddr[9:2]];

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Trace monitor samples mid-cycle when outputs have settled
    always @(negedge clk) begin
        if (!reset && grfWe === 1'b1) begin
            recAddr.push_back(grfAddr);
            recValue.push_back(grfWdata);
            recPc.push_back(wbInstAddr);
        end
        if (!reset && (|dataByteen) === 1'b1) begin
            recStAddr.push_back(dataAddr);
            recStData.push_back(dataWdata);
            recStEn.push_back(dataByteen);
            recStPc.push_back(memInstAddr);
            for (int i = 0; i < 4; i++) begin
                if (dataByteen[i]) dmem[dataAddr[9:2]][8*i +: 8] = dataWdata[8*i +: 8];
            end
        end
    end

    initial begin
        #((programWords * 10 + 100) * clkPeriod);  // 10 cycles per word plus slack
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    function automatic wordT rType(regAddrT rs, regAddrT rt, regAddrT rd, logic [5:0] funct);
        return {`OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic wordT iType(logic [5:0] opc, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic wordT jalTo(wordT target);
        return {`OPC_JAL, target[27:2]};
    endfunction

    task automatic clearProgram();
        @(posedge clk);
        #inputDelay;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
        end
        progLen = 0;
    endtask

    task automatic emit(input wordT instr);
        imem[progLen] = instr;
        progLen++;
    endtask

    task automatic resetDut();
        @(posedge clk);
        #inputDelay reset = 1'b1;
        repeat (4) @(posedge clk);
        #inputDelay reset = 1'b0;
        recAddr.delete();
        recValue.delete();
        recPc.delete();
        recStAddr.delete();
        recStData.delete();
        recStEn.delete();
        recStPc.delete();
    endtask

    task automatic writeModelReg(input regAddrT r, input wordT v, input wordT pc);
        if (r != '0) begin  // r0 stays zero
            modelRegs[r] = v;
            expAddr.push_back(r);
            expValue.push_back(v);
            expPc.push_back(pc);
        end
    endtask

    // In-order ISA model with one delay slot
    task automatic runModel(input int len);
        wordT    pc;
        wordT    npc;
        wordT    nnpc;
        wordT    instr;
        wordT    a;
        wordT    b;
        wordT    simm;
        wordT    ea;
        wordT    off;
        int      steps;
        expAddr.delete();
        expValue.delete();
        expPc.delete();
        expStAddr.delete();
        expStData.delete();
        expStPc.delete();
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'h0;
        end
        pc    = `MIPS_RESET_PC;
        npc   = pc + 32'd4;
        steps = 0;
        while (pc >= `MIPS_RESET_PC && pc < `MIPS_RESET_PC + 4 * len && steps < 200) begin
            off   = pc - `MIPS_RESET_PC;
            instr = imem[off[7:2]];
            a     = modelRegs[instr[25:21]];
            b     = modelRegs[instr[20:16]];
            simm  = {{16{instr[15]}}, instr[15:0]};
            ea    = a + simm;
            nnpc  = npc + 32'd4;
            case (instr[31:26])
                `OPC_SPECIAL: begin
                    case (instr[5:0])
                        `FN_ADDU: writeModelReg(instr[15:11], a + b, pc);
                        `FN_SUBU: writeModelReg(instr[15:11], a - b, pc);
                        `FN_JR:   nnpc = a;
                        default: ;
                    endcase
                end
                `OPC_ORI: writeModelReg(instr[20:16], a | {16'h0, instr[15:0]}, pc);
                `OPC_LUI: writeModelReg(instr[20:16], {instr[15:0], 16'h0}, pc);
                `OPC_LW:  writeModelReg(instr[20:16], modelMem[ea[9:2]], pc);
                `OPC_SW: begin
                    modelMem[ea[9:2]] = b;
                    expStAddr.push_back(ea);
                    expStData.push_back(b);
                    expStPc.push_back(pc);
                end
                `OPC_BEQ: if (a == b) nnpc = npc + {simm[29:0], 2'b00};  // From delay slot
                `OPC_JAL: begin
                    writeModelReg(`MIPS_REG_RA, pc + 32'd8, pc);
                    nnpc = {npc[31:28], instr[25:0], 2'b00};
                end
                default: ;
            endcase
            pc  = npc;
            npc = nnpc;
            steps++;
        end
    endtask

    task automatic checkWord(input string name, input wordT exp, input wordT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkByteen(input string name, input logic [3:0] exp, input logic [3:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("mismatch %s: byte enable expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkWrite(input string name, input regAddrT addr, input wordT value,
                              input wordT pc);
        regAddrT actAddr;
        wordT    actValue;
        wordT    actPc;
        checkCount++;
        if (recAddr.size() == 0) begin
            errorCount++;
            $display("%s: write of r%0d from pc %h never happened", name, addr, pc);
            return;
        end
        actAddr  = recAddr.pop_front();
        actValue = recValue.pop_front();
        actPc    = recPc.pop_front();
        if (actAddr !== addr || actValue !== value || actPc !== pc) begin
            errorCount++;
            $display("mismatch %s: expected r%0d=%h pc %h, actual r%0d=%h pc %h",
                     name, addr, value, pc, actAddr, actValue, actPc);
        end
    endtask

    task automatic checkStore(input string name, input wordT addr, input wordT data);
        wordT actAddr;
        wordT actData;
        if (recStAddr.size() == 0) begin
            errorCount++;
            $display("%s: store to %h never happened", name, addr);
            return;
        end
        actAddr = recStAddr.pop_front();
        actData = recStData.pop_front();
        checkByteen(name, 4'b1111, recStEn.pop_front());  // Word store only
        checkCount++;
        if (actAddr !== addr || actData !== data) begin
            errorCount++;
            $display("mismatch %s: store expected [%h]=%h, actual [%h]=%h",
                     name, addr, data, actAddr, actData);
        end
    endtask

    // Model the program, run it on the DUT, compare traces
    task automatic runAndCheck(input string name);
        int   cycles;
        int   expWrites;
        int   expStores;
        wordT stPc;
        runModel(progLen);
        expWrites = expAddr.size();
        expStores = expStAddr.size();
        resetDut();
        cycles = 0;
        while ((recAddr.size() < expWrites || recStAddr.size() < expStores) &&
               cycles < progLen * 10) begin
            @(posedge clk);
            cycles++;
        end
        if (recAddr.size() < expWrites || recStAddr.size() < expStores) begin
            errorCount++;
            $display("%s: timed out waiting for register writes or stores", name);
        end
        repeat (10) @(posedge clk);  // Room for stray writes
        while (expAddr.size() > 0) begin
            checkWrite(name, expAddr.pop_front(), expValue.pop_front(), expPc.pop_front());
        end
        while (expStAddr.size() > 0) begin
            stPc = expStPc.pop_front();
            if (recStPc.size() > 0) begin
                checkWord({name, " store pc"}, stPc, recStPc.pop_front());  // M stage PC
            end
            checkStore(name, expStAddr.pop_front(), expStData.pop_front());
        end
        if (recAddr.size() != 0 || recStAddr.size() != 0) begin
            errorCount++;
            $display("%s: %0d unexpected register writes and %0d unexpected stores",
                     name, recAddr.size(), recStAddr.size());
        end
    endtask

    task automatic testReset();
        clearProgram();
        resetDut();
        @(negedge clk);
        checkWord("reset", `MIPS_RESET_PC, instAddr);
        checkFlag("reset", 1'b0, grfWe);
        checkByteen("reset", 4'b0000, dataByteen);
    endtask

    task automatic testAluChain();
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        a = 16'($urandom());
        b = 16'($urandom());
        c = 16'($urandom());
        clearProgram();
        emit(iType(`OPC_ORI, 0, 1, a));
        emit(iType(`OPC_LUI, 0, 2, b));
        emit(rType(1, 2, 3, `FN_ADDU));  // r1 from W, r2 from M
        emit(rType(3, 1, 4, `FN_SUBU));
        emit(iType(`OPC_ORI, 4, 5, c));
        emit(rType(5, 3, 6, `FN_ADDU));
        emit(rType(6, 2, 7, `FN_SUBU));
        runAndCheck("aluChain");
    endtask

    task automatic testMemory();
        logic [15:0] hi;
        logic [15:0] lo;
        logic [15:0] v;
        hi = 16'($urandom());
        lo = 16'($urandom());
        v  = 16'($urandom());
        clearProgram();
        emit(iType(`OPC_ORI, 0, 8, 16'h0040));  // Base address
        emit(iType(`OPC_LUI, 0, 9, hi));
        emit(iType(`OPC_ORI, 9, 9, lo));
        emit(iType(`OPC_ORI, 0, 10, v));
        emit(iType(`OPC_SW, 8, 9, 16'd0));
        emit(iType(`OPC_SW, 8, 10, 16'd4));
        emit(iType(`OPC_LW, 8, 11, 16'd0));
        emit(rType(11, 10, 12, `FN_ADDU));    // Load-use stall
        emit(iType(`OPC_LW, 8, 13, 16'd4));
        emit(iType(`OPC_SW, 8, 13, 16'd8));   // Store data via W
        emit(iType(`OPC_LW, 8, 14, 16'd8));
        emit(rType(14, 9, 15, `FN_SUBU));
        runAndCheck("memory");
    endtask

    task automatic testBranches();
        logic [15:0] v;
        v = 16'($urandom());
        clearProgram();
        emit(iType(`OPC_ORI, 0, 1, v));
        emit(iType(`OPC_ORI, 0, 2, v));
        emit(iType(`OPC_BEQ, 1, 2, 16'd2));    // Taken with r2 still in E
        emit(iType(`OPC_ORI, 0, 3, 16'h0011));  // Delay slot
        emit(iType(`OPC_ORI, 0, 4, 16'h0022));  // Skipped
        emit(iType(`OPC_ORI, 0, 5, v + 16'd1));
        emit(iType(`OPC_BEQ, 1, 5, 16'd1));    // Not taken
        emit(iType(`OPC_ORI, 0, 6, 16'h0044));
        emit(iType(`OPC_ORI, 0, 7, 16'h0055));
        emit(iType(`OPC_SW, 0, 1, 16'd0));
        emit(iType(`OPC_LW, 0, 8, 16'd0));
        emit(iType(`OPC_BEQ, 8, 1, 16'd2));    // Two stall cycles behind lw
        emit(iType(`OPC_ORI, 0, 9, 16'h0066));
        emit(iType(`OPC_ORI, 0, 10, 16'h0077)); // Skipped
        emit(iType(`OPC_ORI, 0, 11, 16'h0088));
        runAndCheck("branches");
    endtask

    task automatic testJumps();
        logic [15:0] v;
        v = 16'($urandom());
        clearProgram();
        emit(iType(`OPC_ORI, 0, 1, v));
        emit(jalTo(`MIPS_RESET_PC + 32'd28));   // Call word 7
        emit(iType(`OPC_ORI, 0, 2, 16'h0012));
        emit(rType(1, 31, 3, `FN_ADDU));         // Return lands here
        emit(iType(`OPC_BEQ, 0, 0, 16'd4));    // Skip over the callee
        emit(iType(`OPC_ORI, 0, 4, 16'h0034));
        emit(iType(`OPC_ORI, 0, 5, 16'h0056));
        emit(iType(`OPC_ORI, 0, 6, 16'h0078));
        emit(rType(31, 0, 0, `FN_JR));
        emit(iType(`OPC_ORI, 0, 7, 16'h009a));  // jr delay slot and beq target
        runAndCheck("jumps");
    endtask

    initial begin
        void'($urandom(56812));
        reset      = 1'b1;
        errorCount = 0;
        checkCount = 0;
        progLen    = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'hd0d0_0000 | (i << 2);  // Byte address as contents
        end
        testReset();
        testAluChain();
        testMemory();
        testBranches();
        testJumps();
        $display("Finished %0d checks with %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/mips.sv
`timescale 1ns/1ps
`default_nettype none

module mips (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::wordT    instRdata,
    output mipsPkg::wordT    instAddr,     // F PC
    input  mipsPkg::wordT    dataRdata,
    output mipsPkg::wordT    dataAddr,
    output mipsPkg::wordT    dataWdata,
    output logic [3:0]       dataByteen,
    output mipsPkg::wordT    memInstAddr,  // M PC
    output logic             grfWe,
    output mipsPkg::regAddrT grfAddr,
    output mipsPkg::wordT    grfWdata,
    output mipsPkg::wordT    wbInstAddr    // W PC
);
    import mipsPkg::*;

    regAddrT   execDest;
    logic      execWe;
    stageTimeT execTnew;
    wordT      execResult;
    wordT      execStoreData;
    ctrlS      execCtrl;
    regAddrT   execRegDest;
    wordT      execPc;

    fetchIf      fetchBus ();
    decodeExecIf decodeExecBus ();
    memBypassIf  memBypassBus ();
    writebackIf  writebackBus ();

    fetchStage fetchUnit (
        .clk      (clk),
        .reset    (reset),
        .instAddr (instAddr),
        .instRdata(instRdata),
        .fetch    (fetchBus)
    );

    decodeStage decodeUnit (
        .clk      (clk),
        .reset    (reset),
        .fetch    (fetchBus),
        .toExec   (decodeExecBus),
        .memBypass(memBypassBus),
        .wb       (writebackBus),
        .execDest (execDest),
        .execWe   (execWe),
        .execTnew (execTnew)
    );

    executeStage executeUnit (
        .clk       (clk),
        .reset     (reset),
        .fromDecode(decodeExecBus),
        .memBypass (memBypassBus),
        .wb        (writebackBus),
        .execDest  (execDest),
        .execWe    (execWe),
        .execTnew  (execTnew),
        .result    (execResult),
        .storeData (execStoreData),
        .ctrl      (execCtrl),
        .dest      (execRegDest),
        .pc        (execPc)
    );

    memoryStage memoryUnit (
        .clk        (clk),
        .reset      (reset),
        .result     (execResult),
        .storeData  (execStoreData),
        .ctrl       (execCtrl),
        .dest       (execRegDest),
        .pc         (execPc),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataByteen (dataByteen),
        .dataRdata  (dataRdata),
        .memInstAddr(memInstAddr),
        .memBypass  (memBypassBus),
        .wb         (writebackBus)
    );

    // GRF write port trace
    assign grfWe      = writebackBus.we;
    assign grfAddr    = writebackBus.regAddr;
    assign grfWdata   = writebackBus.value;
    assign wbInstAddr = writebackBus.pc;

endmodule

`default_nettype wire

// File: hdl/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::wordT    result,
    input  mipsPkg::wordT    storeData,
    input  mipsPkg::ctrlS    ctrl,
    input  mipsPkg::regAddrT dest,
    input  mipsPkg::wordT    pc,
    output mipsPkg::wordT    dataAddr,
    output mipsPkg::wordT    dataWdata,
    output logic [3:0]       dataByteen,
    input  mipsPkg::wordT    dataRdata,  // Combinational read
    output mipsPkg::wordT    memInstAddr,
    memBypassIf.source       memBypass,
    writebackIf.source       wb
);
    import mipsPkg::*;

    ctrlS    mCtrl;
    regAddrT mDest;
    wordT    mPc;
    wordT    mResult;
    wordT    mStoreData;

    // E/M register
    always_ff @(posedge clk) begin
        if (reset) begin
            mCtrl <= '0;
            mDest <= '0;
            mPc   <= '0;
        end else begin
            mCtrl <= ctrl;
            mDest <= dest;
            mPc   <= pc;
        end
    end

    always_ff @(posedge clk) begin
        mResult    <= result;
        mStoreData <= storeData;
    end

    assign memBypass.we          = mCtrl.regWrite;
    assign memBypass.regAddr     = mDest;
    assign memBypass.value       = mResult;
    assign memBypass.loadPending = mCtrl.memRead;

    // Data bus, word access only
    assign dataAddr    = mResult;
    assign dataWdata   = (wb.we && wb.regAddr == mDest) ? wb.value : mStoreData;  // lw then sw
    assign dataByteen  = mCtrl.memWrite ? 4'b1111 : 4'b0000;
    assign memInstAddr = mPc;

    // M/W register
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.we      <= 1'b0;
            wb.regAddr <= '0;
            wb.pc      <= '0;
        end else begin
            wb.we      <= mCtrl.regWrite;
            wb.regAddr <= mDest;
            wb.pc      <= mPc;
        end
    end

    always_ff @(posedge clk) begin
        wb.value <= mCtrl.memRead ? dataRdata : mResult;
    end

endmodule

`default_nettype wire

// File: hdl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic               clk,
    input  logic               reset,
    decodeExecIf.exec          fromDecode,
    memBypassIf.sink           memBypass,
    writebackIf.sink           wb,
    output mipsPkg::regAddrT   execDest,  // Back to D for stall checks
    output logic               execWe,
    output mipsPkg::stageTimeT execTnew,
    output mipsPkg::wordT      result,
    output mipsPkg::wordT      storeData,
    output mipsPkg::ctrlS      ctrl,
    output mipsPkg::regAddrT   dest,
    output mipsPkg::wordT      pc
);
    import mipsPkg::*;

    regAddrT rsAddr;
    regAddrT rtAddr;
    wordT    rsValue;
    wordT    rtValue;
    wordT    imm;
    wordT    srcA;
    wordT    srcB;
    wordT    aluResult;

    // D/E register, a bubble loads a nop
    always_ff @(posedge clk) begin
        if (reset || fromDecode.bubble) begin
            ctrl   <= '0;
            dest   <= '0;
            pc     <= '0;
            rsAddr <= '0;
            rtAddr <= '0;
        end else begin
            ctrl   <= fromDecode.ctrl;
            dest   <= fromDecode.dest;
            pc     <= fromDecode.pc;
            rsAddr <= fromDecode.rsAddr;
            rtAddr <= fromDecode.rtAddr;
        end
    end

    always_ff @(posedge clk) begin
        rsValue <= fromDecode.rsValue;
        rtValue <= fromDecode.rtValue;
        imm     <= fromDecode.imm;
    end

    // M, then W, then the value read in D
    assign srcA = (memBypass.we && !memBypass.loadPending && memBypass.regAddr == rsAddr) ?
                  memBypass.value : (wb.we && wb.regAddr == rsAddr) ? wb.value : rsValue;
    assign storeData = (memBypass.we && !memBypass.loadPending && memBypass.regAddr == rtAddr) ?
                       memBypass.value : (wb.we && wb.regAddr == rtAddr) ? wb.value : rtValue;
    assign srcB = ctrl.useImm ? imm : storeData;

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluOr:   aluResult = srcA | srcB;
            aluLui:  aluResult = {srcB[15:0], 16'h0};
            default: aluResult = srcA + srcB;
        endcase
    end

    assign result = ctrl.link ? pc + 32'd8 : aluResult;  // jal link past delay slot

    assign execDest = dest;
    assign execWe   = ctrl.regWrite;
    assign execTnew = ctrl.tnewExec;

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module decodeStage (
    input  logic               clk,
    input  logic               reset,
    fetchIf.decode             fetch,
    decodeExecIf.decode        toExec,
    memBypassIf.sink           memBypass,
    writebackIf.sink           wb,
    input  mipsPkg::regAddrT   execDest,  // Producer now in E
    input  logic               execWe,
    input  mipsPkg::stageTimeT execTnew
);
    import mipsPkg::*;

    wordT      dInstr;
    wordT      dPc;
    wordT      pcPlus4;
    wordT      imm;
    wordT      rfRs;
    wordT      rfRt;
    wordT      rsFwd;
    wordT      rtFwd;
    regAddrT   rs;
    regAddrT   rt;
    regAddrT   rd;
    regAddrT   dest;
    opcodeE    op;
    ctrlS      ctrl;
    stageTimeT tuseRs;
    stageTimeT tuseRt;
    stageTimeT memTnew;
    logic      stallRs;
    logic      stallRt;
    logic      stall;

    // F/D register, frozen on stall
    always_ff @(posedge clk) begin
        if (reset) begin
            dInstr <= '0;  // nop
            dPc    <= '0;
        end else if (!stall) begin
            dInstr <= fetch.instr;
            dPc    <= fetch.pc;
        end
    end

    assign rs      = dInstr[25:21];
    assign rt      = dInstr[20:16];
    assign rd      = dInstr[15:11];
    assign pcPlus4 = dPc + 32'd4;
    // Zero extend for ori/lui, sign extend otherwise
    assign imm = (op == opOri || op == opLui) ? {16'h0, dInstr[15:0]}
                                              : {{16{dInstr[15]}}, dInstr[15:0]};

    registerFile regFile (
        .clk    (clk),
        .reset  (reset),
        .rsAddr (rs),
        .rtAddr (rt),
        .rsValue(rfRs),
        .rtValue(rfRt),
        .wb     (wb)
    );

    // M first, then W; a pending load is covered by the stall
    assign rsFwd = (memBypass.we && !memBypass.loadPending && memBypass.regAddr == rs) ?
                   memBypass.value : (wb.we && wb.regAddr == rs) ? wb.value : rfRs;
    assign rtFwd = (memBypass.we && !memBypass.loadPending && memBypass.regAddr == rt) ?
                   memBypass.value : (wb.we && wb.regAddr == rt) ? wb.value : rfRt;

    always_comb begin
        case (dInstr[31:26])
            `OPC_SPECIAL: begin
                case (dInstr[5:0])
                    `FN_ADDU: op = opAddu;
                    `FN_SUBU: op = opSubu;
                    `FN_JR:   op = opJr;
                    default:  op = opNop;  // All-zero word lands here
                endcase
            end
            `OPC_ORI: op = opOri;
            `OPC_LUI: op = opLui;
            `OPC_LW:  op = opLw;
            `OPC_SW:  op = opSw;
            `OPC_BEQ: op = opBeq;
            `OPC_JAL: op = opJal;
            default:  op = opNop;
        endcase
    end

    // Control, destination and Tuse; Tuse 3 means source unused
    always_comb begin
        ctrl    = '0;
        ctrl.op = op;
        dest    = rt;  // sw keeps rt here for store-data forwarding
        tuseRs  = 2'd3;
        tuseRt  = 2'd3;
        case (op)
            opAddu, opSubu: begin
                ctrl.aluOp    = (op == opSubu) ? aluSub : aluAdd;
                ctrl.regWrite = 1'b1;
                ctrl.tnewExec = 2'd1;
                dest          = rd;
                tuseRs        = 2'd1;
                tuseRt        = 2'd1;
            end
            opOri, opLui: begin
                ctrl.aluOp    = (op == opLui) ? aluLui : aluOr;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.tnewExec = 2'd1;
                tuseRs        = (op == opOri) ? 2'd1 : 2'd3;
            end
            opLw: begin
                ctrl.useImm   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.tnewExec = 2'd2;  // Data back in W
                tuseRs        = 2'd1;
            end
            opSw: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
                tuseRs        = 2'd1;
                tuseRt        = 2'd2;  // Store data needed in M
            end
            opBeq: begin
                tuseRs = 2'd0;  // Compared here in D
                tuseRt = 2'd0;
            end
            opJal: begin
                ctrl.link     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.tnewExec = 2'd1;
                dest          = `MIPS_REG_RA;
            end
            opJr: tuseRs = 2'd0;
            default: ;
        endcase
        ctrl.regWrite = ctrl.regWrite && (dest != '0);  // r0 never a producer
    end

    // Branch and jump targets
    always_comb begin
        fetch.redirect = 1'b0;
        fetch.target   = pcPlus4 + {imm[29:0], 2'b00};
        case (op)
            opBeq: fetch.redirect = (rsFwd == rtFwd);
            opJal: begin
                fetch.redirect = 1'b1;
                fetch.target   = {pcPlus4[31:28], dInstr[25:0], 2'b00};
            end
            opJr: begin
                fetch.redirect = 1'b1;
                fetch.target   = rsFwd;
            end
            default: ;
        endcase
    end

    // Stall while Tuse < Tnew of a matching producer in E or M
    assign memTnew = memBypass.loadPending ? 2'd1 : 2'd0;
    assign stallRs = (execWe && execDest == rs && tuseRs < execTnew) ||
                     (memBypass.we && memBypass.regAddr == rs && tuseRs < memTnew);
    assign stallRt = (execWe && execDest == rt && tuseRt < execTnew) ||
                     (memBypass.we && memBypass.regAddr == rt && tuseRt < memTnew);
    assign stall   = stallRs || stallRt;

    assign fetch.hold     = stall;
    assign toExec.bubble  = stall;
    assign toExec.pc      = dPc;
    assign toExec.ctrl    = ctrl;
    assign toExec.rsAddr  = rs;
    assign toExec.rtAddr  = rt;
    assign toExec.rsValue = rsFwd;
    assign toExec.rtValue = rtFwd;
    assign toExec.imm     = imm;
    assign toExec.dest    = dest;

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::regAddrT rsAddr,
    input  mipsPkg::regAddrT rtAddr,
    output mipsPkg::wordT    rsValue,
    output mipsPkg::wordT    rtValue,
    writebackIf.sink         wb
);
    import mipsPkg::*;

    wordT regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.regAddr != '0) begin
            regs[wb.regAddr] <= wb.value;
        end
    end

    // Write-through so D sees W's result in the same cycle
    assign rsValue = (rsAddr == '0) ? '0 :
                     (wb.we && wb.regAddr == rsAddr) ? wb.value : regs[rsAddr];
    assign rtValue = (rtAddr == '0) ? '0 :
                     (wb.we && wb.regAddr == rtAddr) ? wb.value : regs[rtAddr];

endmodule

`default_nettype wire

// File: hdl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module fetchStage (
    input  logic          clk,
    input  logic          reset,
    output mipsPkg::wordT instAddr,   // To instruction memory
    input  mipsPkg::wordT instRdata,  // Comes back same cycle
    fetchIf.fetch         fetch
);
    import mipsPkg::*;

    wordT pc;
    wordT nextPc;

    // Hold beats redirect, a stalled branch may see stale operands
    always_comb begin
        if (fetch.hold) begin
            nextPc = pc;
        end else if (fetch.redirect) begin
            nextPc = fetch.target;
        end else begin
            nextPc = pc + 32'd4;  // Sequential, also the delay slot
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    assign instAddr    = pc;
    assign fetch.pc    = pc;
    assign fetch.instr = instRdata;

endmodule

`default_nettype wire

// File: hdl/mipsIfs.sv
`timescale 1ns/1ps
`default_nettype none

// F to D, plus the PC steering back from D
interface fetchIf;
    import mipsPkg::*;
    wordT pc;
    wordT instr;
    logic hold;      // Keep PC, stall
    logic redirect;  // Take target next
    wordT target;
    modport fetch (output pc, instr, input hold, redirect, target);
    modport decode (input pc, instr, output hold, redirect, target);
endinterface

// D to E register inputs
interface decodeExecIf;
    import mipsPkg::*;
    wordT    pc;
    ctrlS    ctrl;
    regAddrT rsAddr;
    regAddrT rtAddr;
    wordT    rsValue;
    wordT    rtValue;
    wordT    imm;
    regAddrT dest;
    logic    bubble;  // Load a nop into E
    modport decode (output pc, ctrl, rsAddr, rtAddr, rsValue, rtValue, imm, dest, bubble);
    modport exec (input pc, ctrl, rsAddr, rtAddr, rsValue, rtValue, imm, dest, bubble);
endinterface

// Bypass out of the E/M register
interface memBypassIf;
    import mipsPkg::*;
    logic    we;
    regAddrT regAddr;
    wordT    value;
    logic    loadPending;  // lw in M, data not back yet
    modport source (output we, regAddr, value, loadPending);
    modport sink (input we, regAddr, value, loadPending);
endinterface

// M/W register, the GPR write port
interface writebackIf;
    import mipsPkg::*;
    logic    we;
    regAddrT regAddr;
    wordT    value;
    wordT    pc;
    modport source (output we, regAddr, value, pc);
    modport sink (input we, regAddr, value, pc);
endinterface

`default_nettype wire

// File: hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] wordT;     // Data or address word
    typedef logic [4:0]  regAddrT;  // GPR number

    // Decoded instruction kind
    typedef enum logic [3:0] {
        opNop,
        opAddu,
        opSubu,
        opOri,
        opLui,
        opLw,
        opSw,
        opBeq,
        opJal,
        opJr
    } opcodeE;

    typedef enum logic [1:0] {
        aluAdd,  // Also address calc for lw/sw
        aluSub,
        aluOr,
        aluLui   // Immediate to upper half
    } aluOpE;

    // Cycles until operand needed (Tuse) or result ready (Tnew)
    typedef logic [1:0] stageTimeT;

    // Control decoded once in D, carried down to W
    typedef struct packed {
        opcodeE    op;
        aluOpE     aluOp;
        logic      useImm;    // ALU B from immediate
        logic      memWrite;
        logic      memRead;
        logic      regWrite;  // Never set for r0
        logic      link;      // Result is PC+8
        stageTimeT tnewExec;  // Tnew while in E
    } ctrlS;

endpackage

`default_nettype wire

// File: include/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000
`define MIPS_REG_RA   5'd31  // Link register for jal

// Primary opcode field, instr[31:26]
`define OPC_SPECIAL 6'h00
`define OPC_BEQ     6'h04
`define OPC_JAL     6'h03
`define OPC_ORI     6'h0d
`define OPC_LUI     6'h0f
`define OPC_LW      6'h23
`define OPC_SW      6'h2b

// Funct field of SPECIAL, instr[5:0]
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23

`endif
